//--- hw/eth_pkg.sv
`default_nettype none

package eth_pkg;

  // ----------------------------------------
  // Width types
  // ----------------------------------------
  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] ethertype_t;
  typedef logic [7:0]  byte_t;
  typedef logic [7:0]  buf_addr_t;
  // Payload length, legal range 1 to 256
  typedef logic [8:0]  pay_len_t;
  typedef logic [31:0] crc_t;
  // Host register bus
  typedef logic [1:0]  reg_addr_t;
  typedef logic [31:0] reg_word_t;

  // ----------------------------------------
  // Frame layout
  // ----------------------------------------
  localparam int    PAY_DEPTH     = 256;
  localparam int    PREAMBLE_LEN  = 7;
  localparam byte_t PREAMBLE_BYTE = 8'h55;
  localparam byte_t SFD_BYTE      = 8'hD5;
  // Short payloads padded up to this
  localparam int    MIN_PAYLOAD   = 46;
  localparam int    HDR_LEN       = 14;
  localparam int    FCS_LEN       = 4;
  // Interframe gap in byte times
  localparam int    IFG_LEN       = 12;

  // CRC-32 preset and generator, MSB-first form
  localparam crc_t CRC_INIT = 32'hFFFF_FFFF;
  localparam crc_t CRC_POLY = 32'h04C1_1DB7;

  // Register word addresses
  localparam reg_addr_t REG_DST_LO = 2'd0;
  localparam reg_addr_t REG_DST_HI = 2'd1;
  localparam reg_addr_t REG_SRC_LO = 2'd2;
  localparam reg_addr_t REG_SRC_HI = 2'd3;

  // Register reset values, broadcast destination and IPv4 type
  localparam mac_addr_t  DST_MAC_RST   = 48'hFFFF_FFFF_FFFF;
  localparam mac_addr_t  SRC_MAC_RST   = 48'h0;
  localparam ethertype_t ETHERTYPE_RST = 16'h0800;

  // ----------------------------------------
  // Bundles
  // ----------------------------------------
  // Header fields in wire order, first member sent first
  typedef struct packed {
    mac_addr_t  dst_mac;
    mac_addr_t  src_mac;
    ethertype_t ethertype;
  } eth_cfg_t;

  typedef struct packed {
    logic  tx_en;
    byte_t txd;
  } gmii_tx_t;

  typedef struct packed {
    logic      we;
    buf_addr_t addr;
    byte_t     data;
  } buf_wr_t;

  typedef enum logic [3:0] {
    S_IDLE,
    S_PREAMBLE,
    S_SFD,
    S_HEADER,
    S_PAYLOAD,
    S_PAD,
    S_FCS,
    S_GAP,
    S_ACK
  } tx_state_t;

  // Mirror a byte, bit 0 swaps with bit 7
  function automatic byte_t bit_rev8(input byte_t b);
    byte_t r;
    for (int i = 0; i < 8; i++) begin
      r[i] = b[7 - i];
    end
    return r;
  endfunction

endpackage

`default_nettype wire

//--- hw/crc32_d8.sv
`default_nettype none

module crc32_d8 (
  input  logic         clk,
  input  logic         resetn,
  input  eth_pkg::byte_t data,
  input  logic         crc_en,
  input  logic         crc_clr,
  output eth_pkg::crc_t  crc_data,
  output eth_pkg::crc_t  crc_next
);

  // ----------------------------------------
  // Byte-wide CRC-32 step
  // ----------------------------------------
  // Ethernet sends each byte LSB first, so the byte is mirrored
  // and then fed MSB first into the shift form of the register
  eth_pkg::byte_t data_rev;

  assign data_rev = eth_pkg::bit_rev8(data);

  // Eight serial steps folded into one cycle
  // Unrolled loop reduces to the parallel XOR equations of
  // x^32+x^26+x^23+x^22+x^16+x^12+x^11+x^10+x^8+x^7+x^5+x^4+x^2+x+1
  function automatic eth_pkg::crc_t crc_step(
    input eth_pkg::crc_t  c,
    input eth_pkg::byte_t d
  );
    eth_pkg::crc_t r;
    logic          fb;
    r = c;
    // d[7] enters first, d[0] last
    for (int i = 7; i >= 0; i--) begin
      fb = r[31] ^ d[i];
      r  = {r[30:0], 1'b0};
      if (fb) begin
        r = r ^ eth_pkg::CRC_POLY;
      end
    end
    return r;
  endfunction

  assign crc_next = crc_step(crc_data, data_rev);

  // ----------------------------------------
  // Register
  // ----------------------------------------
  // Clear wins over enable
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      crc_data <= eth_pkg::CRC_INIT;
    end else if (crc_clr) begin
      crc_data <= eth_pkg::CRC_INIT;
    end else if (crc_en) begin
      crc_data <= crc_next;
    end
  end

endmodule

`default_nettype wire

//--- hw/eth_cfg_regs.sv
`default_nettype none

module eth_cfg_regs (
  input  logic                clk,
  input  logic                resetn,
  input  logic                cfg_we,
  input  eth_pkg::reg_addr_t  cfg_addr,
  input  eth_pkg::reg_word_t  cfg_wdata,
  output eth_pkg::eth_cfg_t   cfg
);

  // ----------------------------------------
  // Word map
  // ----------------------------------------
  // 0  dst_mac[31:0]
  // 1  dst_mac[47:32] in bits 15:0
  // 2  src_mac[31:0]
  // 3  src_mac[47:32] in bits 15:0, ethertype in bits 31:16
  //
  // Fields drive the sequencer directly
  // Sequencer latches them at frame start

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      cfg.dst_mac   <= eth_pkg::DST_MAC_RST;
      cfg.src_mac   <= eth_pkg::SRC_MAC_RST;
      cfg.ethertype <= eth_pkg::ETHERTYPE_RST;
    end else if (cfg_we) begin
      case (cfg_addr)
        eth_pkg::REG_DST_LO: begin
          cfg.dst_mac[31:0] <= cfg_wdata;
        end
        eth_pkg::REG_DST_HI: begin
          // Upper half of the word ignored
          cfg.dst_mac[47:32] <= cfg_wdata[15:0];
        end
        eth_pkg::REG_SRC_LO: begin
          cfg.src_mac[31:0] <= cfg_wdata;
        end
        eth_pkg::REG_SRC_HI: begin
          // Shared word, MAC top and type
          cfg.src_mac[47:32] <= cfg_wdata[15:0];
          cfg.ethertype      <= cfg_wdata[31:16];
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/eth_payload_buf.sv
`default_nettype none

module eth_payload_buf (
  input  logic               clk,
  input  eth_pkg::buf_wr_t   wr,
  input  eth_pkg::buf_addr_t rd_addr,
  output eth_pkg::byte_t     rd_data
);

  // ----------------------------------------
  // Payload memory
  // ----------------------------------------
  // One write port for the host
  // One registered read port for the sequencer
  eth_pkg::byte_t mem [eth_pkg::PAY_DEPTH];

  // Host write
  always_ff @(posedge clk) begin
    if (wr.we) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // Read data one cycle after the address
  // Maps onto a block RAM output register
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

//--- hw/eth_tx_fsm.sv
`default_nettype none

module eth_tx_fsm (
  input  logic               clk,
  input  logic               resetn,
  input  logic               tx_req,
  input  eth_pkg::pay_len_t  tx_len,
  input  eth_pkg::eth_cfg_t  cfg,
  input  eth_pkg::byte_t     rd_data,
  input  eth_pkg::crc_t      crc_data,
  output logic               tx_ack,
  output eth_pkg::buf_addr_t rd_addr,
  output logic               crc_en,
  output logic               crc_clr,
  output eth_pkg::byte_t     crc_byte,
  output eth_pkg::gmii_tx_t  gmii
);

  eth_pkg::tx_state_t state;
  // Byte counter, shared by every state
  eth_pkg::pay_len_t  cnt;
  // Latched length and header
  eth_pkg::pay_len_t  len_q;
  logic [eth_pkg::HDR_LEN*8-1:0] hdr_q;

  logic           start;
  logic           tx_valid;
  eth_pkg::byte_t tx_byte;
  eth_pkg::byte_t fcs_raw;

  // New request only after the previous ack has dropped
  assign start = (state == eth_pkg::S_IDLE) && tx_req && !tx_ack;

  // ----------------------------------------
  // State and counter
  // ----------------------------------------
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state <= eth_pkg::S_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        eth_pkg::S_IDLE: begin
          if (start) begin
            state <= eth_pkg::S_PREAMBLE;
            cnt   <= '0;
          end
        end
        eth_pkg::S_PREAMBLE: begin
          if (cnt == eth_pkg::pay_len_t'(eth_pkg::PREAMBLE_LEN - 1)) begin
            state <= eth_pkg::S_SFD;
            cnt   <= '0;
          end else begin
            cnt <= cnt + eth_pkg::pay_len_t'(1);
          end
        end
        eth_pkg::S_SFD: begin
          state <= eth_pkg::S_HEADER;
          cnt   <= '0;
        end
        eth_pkg::S_HEADER: begin
          if (cnt == eth_pkg::pay_len_t'(eth_pkg::HDR_LEN - 1)) begin
            state <= eth_pkg::S_PAYLOAD;
            cnt   <= '0;
          end else begin
            cnt <= cnt + eth_pkg::pay_len_t'(1);
          end
        end
        eth_pkg::S_PAYLOAD: begin
          if (cnt == len_q - eth_pkg::pay_len_t'(1)) begin
            // Pad keeps counting from the payload length
            if (len_q < eth_pkg::pay_len_t'(eth_pkg::MIN_PAYLOAD)) begin
              state <= eth_pkg::S_PAD;
              cnt   <= cnt + eth_pkg::pay_len_t'(1);
            end else begin
              state <= eth_pkg::S_FCS;
              cnt   <= '0;
            end
          end else begin
            cnt <= cnt + eth_pkg::pay_len_t'(1);
          end
        end
        eth_pkg::S_PAD: begin
          if (cnt == eth_pkg::pay_len_t'(eth_pkg::MIN_PAYLOAD - 1)) begin
            state <= eth_pkg::S_FCS;
            cnt   <= '0;
          end else begin
            cnt <= cnt + eth_pkg::pay_len_t'(1);
          end
        end
        eth_pkg::S_FCS: begin
          if (cnt == eth_pkg::pay_len_t'(eth_pkg::FCS_LEN - 1)) begin
            state <= eth_pkg::S_GAP;
            cnt   <= '0;
          end else begin
            cnt <= cnt + eth_pkg::pay_len_t'(1);
          end
        end
        eth_pkg::S_GAP: begin
          if (cnt == eth_pkg::pay_len_t'(eth_pkg::IFG_LEN - 1)) begin
            state <= eth_pkg::S_ACK;
            cnt   <= '0;
          end else begin
            cnt <= cnt + eth_pkg::pay_len_t'(1);
          end
        end
        eth_pkg::S_ACK: begin
          // Four-phase release
          if (tx_ack && !tx_req) begin
            state <= eth_pkg::S_IDLE;
          end
        end
        default: begin
          state <= eth_pkg::S_IDLE;
          cnt   <= '0;
        end
      endcase
    end
  end

  // ----------------------------------------
  // Frame context
  // ----------------------------------------
  // Config snapshot at accept, later writes hit the next frame
  // Header shifts out MSB first, one byte per header cycle
  always_ff @(posedge clk) begin
    if (start) begin
      len_q <= tx_len;
      hdr_q <= cfg;
    end else if (state == eth_pkg::S_HEADER) begin
      hdr_q <= {hdr_q[eth_pkg::HDR_LEN*8-9:0], 8'h00};
    end
  end

  // Buffer address one cycle ahead of its byte
  // Last header cycle fetches byte 0
  always_comb begin
    if (state == eth_pkg::S_PAYLOAD) begin
      rd_addr = eth_pkg::buf_addr_t'(cnt + eth_pkg::pay_len_t'(1));
    end else begin
      rd_addr = '0;
    end
  end

  // ----------------------------------------
  // Byte select
  // ----------------------------------------
  // FCS from the top register byte down
  always_comb begin
    case (cnt[1:0])
      2'd0:    fcs_raw = crc_data[31:24];
      2'd1:    fcs_raw = crc_data[23:16];
      2'd2:    fcs_raw = crc_data[15:8];
      default: fcs_raw = crc_data[7:0];
    endcase
  end

  always_comb begin
    tx_valid = 1'b1;
    tx_byte  = '0;
    case (state)
      eth_pkg::S_PREAMBLE: tx_byte = eth_pkg::PREAMBLE_BYTE;
      eth_pkg::S_SFD:      tx_byte = eth_pkg::SFD_BYTE;
      eth_pkg::S_HEADER:   tx_byte = hdr_q[eth_pkg::HDR_LEN*8-1 -: 8];
      eth_pkg::S_PAYLOAD:  tx_byte = rd_data;
      // Zero pad
      eth_pkg::S_PAD:      tx_byte = '0;
      // Complement of the mirrored register byte
      eth_pkg::S_FCS:      tx_byte = ~eth_pkg::bit_rev8(fcs_raw);
      default:             tx_valid = 1'b0;
    endcase
  end

  // CRC covers header, payload and pad only
  assign crc_clr  = (state == eth_pkg::S_SFD);
  assign crc_en   = (state == eth_pkg::S_HEADER) ||
                    (state == eth_pkg::S_PAYLOAD) ||
                    (state == eth_pkg::S_PAD);
  assign crc_byte = tx_byte;

  // ----------------------------------------
  // Registered outputs
  // ----------------------------------------
  // Output lags state by one cycle
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      gmii   <= '0;
      tx_ack <= 1'b0;
    end else begin
      gmii.tx_en <= tx_valid;
      gmii.txd   <= tx_byte;
      tx_ack     <= (state == eth_pkg::S_ACK);
    end
  end

endmodule

`default_nettype wire

//--- hw/eth_tx_top.sv
`default_nettype none

module eth_tx_top (
  input  logic               clk,
  input  logic               resetn,
  // Register bus
  input  logic               cfg_we,
  input  eth_pkg::reg_addr_t cfg_addr,
  input  eth_pkg::reg_word_t cfg_wdata,
  // Payload write port
  input  eth_pkg::buf_wr_t   buf_wr,
  // Send handshake
  input  logic               tx_req,
  input  eth_pkg::pay_len_t  tx_len,
  output logic               tx_ack,
  // Byte stream
  output eth_pkg::gmii_tx_t  gmii
);

  // ----------------------------------------
  // Internal nets
  // ----------------------------------------
  eth_pkg::eth_cfg_t  cfg;
  eth_pkg::buf_addr_t rd_addr;
  eth_pkg::byte_t     rd_data;
  logic               crc_en;
  logic               crc_clr;
  eth_pkg::byte_t     crc_byte;
  eth_pkg::crc_t      crc_data;

  // Header fields
  eth_cfg_regs eth_cfg_regs_inst (
    .clk       (clk),
    .resetn    (resetn),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg       (cfg)
  );

  // Payload bytes
  eth_payload_buf eth_payload_buf_inst (
    .clk     (clk),
    .wr      (buf_wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // Frame sequencer
  eth_tx_fsm eth_tx_fsm_inst (
    .clk      (clk),
    .resetn   (resetn),
    .tx_req   (tx_req),
    .tx_len   (tx_len),
    .cfg      (cfg),
    .rd_data  (rd_data),
    .crc_data (crc_data),
    .tx_ack   (tx_ack),
    .rd_addr  (rd_addr),
    .crc_en   (crc_en),
    .crc_clr  (crc_clr),
    .crc_byte (crc_byte),
    .gmii     (gmii)
  );

  // FCS engine, lookahead value not needed here
  crc32_d8 crc32_d8_inst (
    .clk      (clk),
    .resetn   (resetn),
    .data     (crc_byte),
    .crc_en   (crc_en),
    .crc_clr  (crc_clr),
    .crc_data (crc_data),
    .crc_next ()
  );

endmodule

`default_nettype wire

//--- tests/eth_tx_tb.sv
`default_nettype none

module eth_tx_tb;

  timeunit 1ns;
  timeprecision 1ps;

  // One table row per frame
  typedef struct packed {
    eth_pkg::pay_len_t  len;
    logic               wr_cfg;
    eth_pkg::mac_addr_t dst;
    eth_pkg::mac_addr_t src;
    eth_pkg::ethertype_t etype;
  } frame_t;

  logic                clk = 1'b0;
  logic                resetn = 1'b0;
  logic                cfg_we;
  eth_pkg::reg_addr_t  cfg_addr;
  eth_pkg::reg_word_t  cfg_wdata;
  eth_pkg::buf_wr_t    buf_wr;
  logic                tx_req;
  eth_pkg::pay_len_t   tx_len;
  logic                tx_ack;
  eth_pkg::gmii_tx_t   gmii;

  // First row relies on the register reset values
  // Row 4 sends without writes, so it repeats row 3
  frame_t frames [6] = '{
    '{9'd46,  1'b0, 48'hFFFF_FFFF_FFFF, 48'h0000_0000_0000, 16'h0800},
    '{9'd100, 1'b1, 48'h0211_2233_4455, 48'h000A_3501_0203, 16'h0800},
    '{9'd256, 1'b1, 48'h3333_0000_0001, 48'hA4B5_C6D7_E8F9, 16'h86DD},
    '{9'd1,   1'b1, 48'h0180_C200_000E, 48'h5E10_2030_4050, 16'h88B5},
    '{9'd17,  1'b0, 48'h0180_C200_000E, 48'h5E10_2030_4050, 16'h88B5},
    '{9'd45,  1'b1, 48'hFEDC_BA98_7654, 48'h0123_4567_89AB, 16'h0806}
  };

  logic [31:0]    lcg_state = 32'hce08;
  eth_pkg::byte_t pay [256];
  eth_pkg::byte_t exp_q [$];
  eth_pkg::byte_t got_q [$];
  int             value_errs = 0;
  int             proto_errs = 0;

  eth_tx_top eth_tx_top_inst (
    .clk       (clk),
    .resetn    (resetn),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .buf_wr    (buf_wr),
    .tx_req    (tx_req),
    .tx_len    (tx_len),
    .tx_ack    (tx_ack),
    .gmii      (gmii)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // ----------------------------------------
  // Models
  // ----------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Reflected CRC-32, one bit at a time, LSB first
  function automatic logic [31:0] crc32_update_byte(input logic [31:0] crc_in,
                                                    input logic [7:0] b);
    logic [31:0] c;
    c = crc_in ^ {24'h0, b};
    for (int k = 0; k < 8; k++) begin
      if (c[0]) begin
        c = (c >> 1) ^ 32'hEDB8_8320;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  task automatic check_eq(input string name, input logic [63:0] exp,
                          input logic [63:0] got);
    assert (exp == got) else begin
      value_errs++;
      $display("[FAIL] t=%0d ns %s expected %0h got %0h", $time, name, exp, got);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      proto_errs++;
      $display("ERROR at %0d ns: %s", $time, what);
    end
  endtask

  task automatic check_quiet_outputs();
    check_eq("tx_en", 64'(1'b0), 64'(gmii.tx_en));
    check_eq("txd", 64'(8'h00), 64'(gmii.txd));
    check_eq("tx_ack", 64'(1'b0), 64'(tx_ack));
  endtask

  // ----------------------------------------
  // Host side
  // ----------------------------------------
  // All tasks start and end just after a falling edge
  task automatic write_reg(input eth_pkg::reg_addr_t a, input eth_pkg::reg_word_t d);
    cfg_we    = 1'b1;
    cfg_addr  = a;
    cfg_wdata = d;
    @(negedge clk);
    cfg_we    = 1'b0;
  endtask

  task automatic load_payload(input int len);
    for (int i = 0; i < len; i++) begin
      lcg_state     = lcg_next(lcg_state);
      pay[i]        = lcg_state[23:16];
      buf_wr.we     = 1'b1;
      buf_wr.addr   = eth_pkg::buf_addr_t'(i);
      buf_wr.data   = pay[i];
      @(negedge clk);
    end
    buf_wr.we = 1'b0;
  endtask

  // Preamble, SFD, header MSB first, payload, pad, FCS LSB first
  task automatic build_expected(input frame_t f);
    logic [31:0] crc;
    int          plen;
    plen = int'(f.len);
    exp_q.delete();
    for (int i = 0; i < 7; i++) begin
      exp_q.push_back(8'h55);
    end
    exp_q.push_back(8'hD5);
    for (int i = 5; i >= 0; i--) begin
      exp_q.push_back(f.dst[i*8 +: 8]);
    end
    for (int i = 5; i >= 0; i--) begin
      exp_q.push_back(f.src[i*8 +: 8]);
    end
    exp_q.push_back(f.etype[15:8]);
    exp_q.push_back(f.etype[7:0]);
    for (int i = 0; i < plen; i++) begin
      exp_q.push_back(pay[i]);
    end
    for (int i = plen; i < 46; i++) begin
      exp_q.push_back(8'h00);
    end
    // CRC over everything after the SFD
    crc = 32'hFFFF_FFFF;
    for (int i = 8; i < exp_q.size(); i++) begin
      crc = crc32_update_byte(crc, exp_q[i]);
    end
    crc = ~crc;
    exp_q.push_back(crc[7:0]);
    exp_q.push_back(crc[15:8]);
    exp_q.push_back(crc[23:16]);
    exp_q.push_back(crc[31:24]);
  endtask

  task automatic send_frame(input int idx);
    frame_t f;
    int     n;
    f = frames[idx];
    if (f.wr_cfg) begin
      write_reg(2'd0, f.dst[31:0]);
      write_reg(2'd1, {16'h0000, f.dst[47:32]});
      write_reg(2'd2, f.src[31:0]);
      write_reg(2'd3, {f.etype, f.src[47:32]});
    end
    load_payload(int'(f.len));
    build_expected(f);

    // Request, tx_en expected on the second sample
    tx_len = f.len;
    tx_req = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!gmii.tx_en && n < 100);
    check_true(gmii.tx_en, "tx_en never rose after tx_req");
    check_eq("tx_en latency", 64'(2), 64'(n));

    // Collect the stream
    got_q.delete();
    n = 0;
    while (gmii.tx_en && n < 400) begin
      got_q.push_back(gmii.txd);
      @(negedge clk);
      n++;
    end
    check_true(!gmii.tx_en, "tx_en stuck high");
    check_eq($sformatf("tx_en length frame %0d", idx), 64'(exp_q.size()),
             64'(got_q.size()));
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
      check_eq($sformatf("txd[%0d] frame %0d", i, idx), 64'(exp_q[i]), 64'(got_q[i]));
    end

    // Gap, ack 13 cycles after the last FCS byte
    n = 1;
    while (!tx_ack && n < 40) begin
      check_eq("tx_en in gap", 64'(1'b0), 64'(gmii.tx_en));
      @(negedge clk);
      n++;
    end
    check_true(tx_ack, "tx_ack never rose after the frame");
    check_eq("tx_ack delay", 64'(13), 64'(n));

    // Held request, no second frame
    repeat (8) begin
      @(negedge clk);
      check_eq("tx_ack held", 64'(1'b1), 64'(tx_ack));
      check_eq("tx_en while held", 64'(1'b0), 64'(gmii.tx_en));
    end

    // Release, ack falls on the second sample
    tx_req = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      check_eq("tx_en after release", 64'(1'b0), 64'(gmii.tx_en));
    end while (tx_ack && n < 40);
    check_true(!tx_ack, "tx_ack stuck high after tx_req fell");
    check_eq("tx_ack release delay", 64'(2), 64'(n));
    repeat (3) begin
      @(negedge clk);
      check_quiet_outputs();
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    buf_wr    = '0;
    tx_req    = 1'b0;
    tx_len    = '0;
    resetn    = 1'b0;
    repeat (16) begin
      @(negedge clk);
      check_quiet_outputs();
    end
    resetn = 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_quiet_outputs();
    end
    for (int i = 0; i < $size(frames); i++) begin
      send_frame(i);
    end
    repeat (4) @(negedge clk);
    $display("Errors: %0d value mismatches, %0d protocol faults", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Budget of length plus 60 cycles per frame, plus margin
  initial begin
    int cyc;
    cyc = 2000;
    for (int i = 0; i < $size(frames); i++) begin
      cyc += int'(frames[i].len) + 60;
    end
    #(cyc * 8);
    $display("Watchdog expired after %0d cycles, the run did not finish", cyc);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- eth_tx_top.f
hw/eth_pkg.sv
hw/crc32_d8.sv
hw/eth_cfg_regs.sv
hw/eth_payload_buf.sv
hw/eth_tx_fsm.sv
hw/eth_tx_top.sv
tests/eth_tx_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the Ethernet transmitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module eth_tx_tb -Mdir obj_dir -o eth_tx_sim -f eth_tx_top.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/eth_tx_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "RESULT: PASS"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
